// File: src/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_STORE    = 5'b01000,
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef enum logic {
    BUS_READ,
    BUS_WRITE
  } bus_op_e;

endpackage

// File: src/rv_alu.sv
module rv_alu (
  input  rv_core_pkg::alu_op_e i_op,
  input  rv_core_pkg::word_t   i_a,
  input  rv_core_pkg::word_t   i_b,
  output rv_core_pkg::word_t   o_result
);
  import rv_core_pkg::*;

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  always_comb begin
    case (i_op)
      ALU_ADD:  o_result = i_a + i_b;
      ALU_SUB:  o_result = i_a - i_b;
      ALU_SLL:  o_result = i_a << shamt;
      ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, i_a < i_b};
      ALU_XOR:  o_result = i_a ^ i_b;
      ALU_SRL:  o_result = i_a >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  o_result = word_t'($signed(i_a) >>> shamt);
      ALU_OR:   o_result = i_a | i_b;
      ALU_AND:  o_result = i_a & i_b;
      default:  o_result = '0;
    endcase
  end

endmodule

// File: src/rv_regfile.sv
module rv_regfile (
  input  logic                   clk,
  input  logic                   nrst,
  input  rv_core_pkg::reg_addr_t i_raddr1,
  input  rv_core_pkg::reg_addr_t i_raddr2,
  output rv_core_pkg::word_t     o_rdata1,
  output rv_core_pkg::word_t     o_rdata2,
  input  logic                   i_we,
  input  rv_core_pkg::reg_addr_t i_waddr,
  input  rv_core_pkg::word_t     i_wdata
);
  import rv_core_pkg::*;

  word_t regs [2**REG_ADDR_W];

  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (!nrst) begin
      for (int i = 0; i < 2**REG_ADDR_W; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

endmodule

// File: src/rv_decode.sv
module rv_decode (
  input  rv_core_pkg::word_t     i_insn,
  input  rv_core_pkg::word_t     i_pc,
  input  rv_core_pkg::word_t     i_rs1_data,
  input  rv_core_pkg::word_t     i_rs2_data,
  output rv_core_pkg::opcode_e   o_opcode,
  output rv_core_pkg::reg_addr_t o_rs1,
  output rv_core_pkg::reg_addr_t o_rs2,
  output rv_core_pkg::reg_addr_t o_rd,
  output logic                   o_rd_wb,
  output rv_core_pkg::word_t     o_imm,
  output rv_core_pkg::alu_op_e   o_alu_op,
  output rv_core_pkg::word_t     o_op_a,
  output rv_core_pkg::word_t     o_op_b,
  output logic                   o_br_inv
);
  import rv_core_pkg::*;

  logic [2:0] funct3;
  logic       alt;
  opcode_e    opc;

  assign funct3 = i_insn[14:12];
  assign alt    = i_insn[30];

  assign o_rs1    = i_insn[19:15];
  assign o_rs2    = i_insn[24:20];
  assign o_rd     = i_insn[11:7];
  assign o_opcode = opc;

  // BEQ, BGE and BGEU are taken on a zero compare
  assign o_br_inv = ~(funct3[2] ^ funct3[0]);

  always_comb begin
    case (i_insn[6:2])
      OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR, OPC_OP_IMM, OPC_OP,
      OPC_LUI, OPC_AUIPC, OPC_SYSTEM, OPC_MISC_MEM: opc = opcode_e'(i_insn[6:2]);
      // unknown opcodes retire as a no-op
      default: opc = OPC_MISC_MEM;
    endcase
  end

  // immediates
  always_comb begin
    case (opc)
      OPC_STORE:
        o_imm = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
      OPC_BRANCH:
        o_imm = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC:
        o_imm = {i_insn[31:12], 12'h000};
      OPC_JAL:
        o_imm = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
      default:
        o_imm = {{20{i_insn[31]}}, i_insn[31:20]};
    endcase
  end

  always_comb begin
    o_alu_op = ALU_ADD;
    if (opc == OPC_OP || opc == OPC_OP_IMM) begin
      case (funct3)
        3'b000: o_alu_op = (opc == OPC_OP && alt) ? ALU_SUB : ALU_ADD;
        3'b001: o_alu_op = ALU_SLL;
        3'b010: o_alu_op = ALU_SLT;
        3'b011: o_alu_op = ALU_SLTU;
        3'b100: o_alu_op = ALU_XOR;
        3'b101: o_alu_op = alt ? ALU_SRA : ALU_SRL;
        3'b110: o_alu_op = ALU_OR;
        default: o_alu_op = ALU_AND;
      endcase
    end else if (opc == OPC_BRANCH) begin
      // eq/ne via xor, signed and unsigned compares
      case (funct3[2:1])
        2'b00: o_alu_op = ALU_XOR;
        2'b10: o_alu_op = ALU_SLT;
        default: o_alu_op = ALU_SLTU;
      endcase
    end
  end

  // operand select
  always_comb begin
    case (opc)
      OPC_LUI:            o_op_a = '0;
      OPC_AUIPC, OPC_JAL: o_op_a = i_pc;
      default:            o_op_a = i_rs1_data;
    endcase
    case (opc)
      OPC_OP, OPC_BRANCH: o_op_b = i_rs2_data;
      default:            o_op_b = o_imm;
    endcase
  end

  always_comb begin
    case (opc)
      OPC_LOAD, OPC_OP_IMM, OPC_OP, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR:
        o_rd_wb = (o_rd != '0);
      default:
        o_rd_wb = 1'b0;
    endcase
  end

endmodule

// File: src/rv_core_ctrl.sv
module rv_core_ctrl (
  input  logic                   clk,
  input  logic                   nrst,
  input  logic                   i_halt_req,
  input  logic                   i_resume_req,
  input  rv_core_pkg::word_t     i_resume_pc,
  output logic                   o_halt,
  output rv_core_pkg::word_t     o_insn,
  output rv_core_pkg::word_t     o_pc,
  input  rv_core_pkg::opcode_e   i_opcode,
  input  rv_core_pkg::reg_addr_t i_rd,
  input  logic                   i_rd_wb,
  input  rv_core_pkg::word_t     i_imm,
  input  logic                   i_br_inv,
  input  rv_core_pkg::word_t     i_rs1_data,
  input  rv_core_pkg::word_t     i_alu_result,
  input  rv_core_pkg::word_t     i_rs2_data,
  output logic                   o_rf_we,
  output rv_core_pkg::reg_addr_t o_rf_waddr,
  output rv_core_pkg::word_t     o_rf_wdata,
  output logic                   o_bus_req,
  output rv_core_pkg::bus_op_e   o_bus_op,
  output rv_core_pkg::word_t     o_bus_addr,
  output rv_core_pkg::word_t     o_bus_wdata,
  input  logic                   i_bus_done,
  input  rv_core_pkg::word_t     i_bus_rdata
);
  import rv_core_pkg::*;

  typedef enum logic [1:0] {
    ST_HALT,
    ST_FETCH,
    ST_EXEC,
    ST_MEM
  } state_e;

  state_e  state_q;
  word_t   pc_q;
  word_t   insn_q;
  logic    halt_pend_q;
  logic    bus_req_q;
  bus_op_e bus_op_q;
  word_t   bus_addr_q;
  word_t   bus_wdata_q;

  word_t   pc_plus4;
  word_t   jalr_sum;
  word_t   next_pc;
  logic    taken;
  logic    is_mem;
  logic    is_link;
  logic    halt_now;

  assign o_halt      = (state_q == ST_HALT);
  assign o_insn      = insn_q;
  assign o_pc        = pc_q;
  assign o_bus_req   = bus_req_q;
  assign o_bus_op    = bus_op_q;
  assign o_bus_addr  = bus_addr_q;
  assign o_bus_wdata = bus_wdata_q;

  assign pc_plus4 = pc_q + 32'd4;
  assign jalr_sum = i_rs1_data + i_imm;
  assign is_mem   = (i_opcode == OPC_LOAD) || (i_opcode == OPC_STORE);
  assign is_link  = (i_opcode == OPC_JAL) || (i_opcode == OPC_JALR);
  // halt seen now or since the fetch began
  assign halt_now = halt_pend_q | i_halt_req;

  // zero-test polarity comes from funct3
  assign taken = (i_opcode == OPC_BRANCH) && ((|i_alu_result) ^ i_br_inv);

  always_comb begin
    if (taken || (i_opcode == OPC_JAL)) begin
      next_pc = pc_q + i_imm;
    end else if (i_opcode == OPC_JALR) begin
      next_pc = {jalr_sum[XLEN-1:1], 1'b0};
    end else begin
      next_pc = pc_plus4;
    end
  end

  // writeback
  always_comb begin
    o_rf_we    = 1'b0;
    o_rf_waddr = i_rd;
    o_rf_wdata = i_alu_result;
    if (state_q == ST_EXEC && !is_mem) begin
      o_rf_we = i_rd_wb;
      if (is_link) begin
        o_rf_wdata = pc_plus4;
      end
    end else if (state_q == ST_MEM && i_bus_done) begin
      // stores never carry rd_wb
      o_rf_we    = i_rd_wb;
      o_rf_wdata = i_bus_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q     <= ST_HALT;
      bus_req_q   <= 1'b0;
      halt_pend_q <= 1'b0;
    end else begin
      bus_req_q   <= 1'b0;
      halt_pend_q <= halt_now;
      case (state_q)
        ST_HALT: begin
          if (i_resume_req) begin
            state_q     <= ST_FETCH;
            bus_req_q   <= 1'b1;
            halt_pend_q <= i_halt_req;
          end
        end
        ST_FETCH: begin
          if (i_bus_done) begin
            state_q <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (is_mem) begin
            state_q   <= ST_MEM;
            bus_req_q <= 1'b1;
          end else if (halt_now) begin
            state_q <= ST_HALT;
          end else begin
            state_q     <= ST_FETCH;
            bus_req_q   <= 1'b1;
            halt_pend_q <= 1'b0;
          end
        end
        ST_MEM: begin
          if (i_bus_done) begin
            if (halt_now) begin
              state_q <= ST_HALT;
            end else begin
              state_q     <= ST_FETCH;
              bus_req_q   <= 1'b1;
              halt_pend_q <= 1'b0;
            end
          end
        end
        default: state_q <= ST_HALT;
      endcase
    end
  end

  // pc, instruction and request payload
  always_ff @(posedge clk) begin
    case (state_q)
      ST_HALT: begin
        if (i_resume_req) begin
          pc_q       <= i_resume_pc;
          bus_addr_q <= i_resume_pc;
          bus_op_q   <= BUS_READ;
        end
      end
      ST_FETCH: begin
        if (i_bus_done) begin
          insn_q <= i_bus_rdata;
        end
      end
      ST_EXEC: begin
        pc_q <= next_pc;
        if (is_mem) begin
          bus_addr_q  <= i_alu_result;
          bus_wdata_q <= i_rs2_data;
          if (i_opcode == OPC_STORE) begin
            bus_op_q <= BUS_WRITE;
          end else begin
            bus_op_q <= BUS_READ;
          end
        end else begin
          bus_addr_q <= next_pc;
          bus_op_q   <= BUS_READ;
        end
      end
      ST_MEM: begin
        if (i_bus_done) begin
          bus_addr_q <= pc_q;
          bus_op_q   <= BUS_READ;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: src/rv_axil_master.sv
module rv_axil_master (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic                 i_req,
  input  rv_core_pkg::bus_op_e i_op,
  input  rv_core_pkg::word_t   i_addr,
  input  rv_core_pkg::word_t   i_wdata,
  output logic                 o_done,
  output rv_core_pkg::word_t   o_rdata,
  output rv_core_pkg::word_t   o_awaddr,
  output logic                 o_awvalid,
  input  logic                 i_awready,
  output rv_core_pkg::word_t   o_wdata,
  output logic                 o_wvalid,
  input  logic                 i_wready,
  input  logic                 i_bvalid,
  output logic                 o_bready,
  output rv_core_pkg::word_t   o_araddr,
  output logic                 o_arvalid,
  input  logic                 i_arready,
  input  rv_core_pkg::word_t   i_rdata,
  input  logic                 i_rvalid,
  output logic                 o_rready
);
  import rv_core_pkg::*;

  word_t addr_q;
  word_t wdata_q;
  word_t rdata_q;
  logic  aw_pend_q;
  logic  w_pend_q;
  logic  wr_busy_q;
  logic  ar_pend_q;
  logic  rd_busy_q;
  logic  done_q;

  assign o_awaddr  = addr_q;
  assign o_araddr  = addr_q;
  assign o_wdata   = wdata_q;
  assign o_awvalid = aw_pend_q;
  assign o_wvalid  = w_pend_q;
  assign o_arvalid = ar_pend_q;
  // response accepted only after address and data went out
  assign o_bready  = wr_busy_q & ~aw_pend_q & ~w_pend_q;
  assign o_rready  = rd_busy_q & ~ar_pend_q;
  assign o_done    = done_q;
  assign o_rdata   = rdata_q;

  always_ff @(posedge clk) begin
    if (i_req) begin
      addr_q  <= i_addr;
      wdata_q <= i_wdata;
    end
    if (i_rvalid && o_rready) begin
      rdata_q <= i_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!nrst) begin
      aw_pend_q <= 1'b0;
      w_pend_q  <= 1'b0;
      wr_busy_q <= 1'b0;
      ar_pend_q <= 1'b0;
      rd_busy_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (i_req) begin
        if (i_op == BUS_WRITE) begin
          aw_pend_q <= 1'b1;
          w_pend_q  <= 1'b1;
          wr_busy_q <= 1'b1;
        end else begin
          ar_pend_q <= 1'b1;
          rd_busy_q <= 1'b1;
        end
      end
      // aw and w complete independently
      if (aw_pend_q && i_awready) begin
        aw_pend_q <= 1'b0;
      end
      if (w_pend_q && i_wready) begin
        w_pend_q <= 1'b0;
      end
      if (o_bready && i_bvalid) begin
        wr_busy_q <= 1'b0;
        done_q    <= 1'b1;
      end
      if (ar_pend_q && i_arready) begin
        ar_pend_q <= 1'b0;
      end
      if (o_rready && i_rvalid) begin
        rd_busy_q <= 1'b0;
        done_q    <= 1'b1;
      end
    end
  end

endmodule

// File: src/rv_core_top.sv
module rv_core_top (
  input  logic               clk,
  input  logic               nrst,
  input  logic               i_halt_req,
  input  logic               i_resume_req,
  input  rv_core_pkg::word_t i_resume_pc,
  output logic               o_halt,
  output rv_core_pkg::word_t o_awaddr,
  output logic               o_awvalid,
  input  logic               i_awready,
  output rv_core_pkg::word_t o_wdata,
  output logic               o_wvalid,
  input  logic               i_wready,
  input  logic               i_bvalid,
  output logic               o_bready,
  output rv_core_pkg::word_t o_araddr,
  output logic               o_arvalid,
  input  logic               i_arready,
  input  rv_core_pkg::word_t i_rdata,
  input  logic               i_rvalid,
  output logic               o_rready
);
  import rv_core_pkg::*;

  word_t     insn;
  word_t     pc;
  opcode_e   opcode;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  logic      rd_wb;
  word_t     imm;
  alu_op_e   alu_op;
  word_t     op_a;
  word_t     op_b;
  logic      br_inv;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_result;

  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  logic      bus_req;
  bus_op_e   bus_op;
  word_t     bus_addr;
  word_t     bus_wdata;
  logic      bus_done;
  word_t     bus_rdata;

  rv_core_ctrl u_ctrl (
    .clk          (clk),
    .nrst         (nrst),
    .i_halt_req   (i_halt_req),
    .i_resume_req (i_resume_req),
    .i_resume_pc  (i_resume_pc),
    .o_halt       (o_halt),
    .o_insn       (insn),
    .o_pc         (pc),
    .i_opcode     (opcode),
    .i_rd         (rd),
    .i_rd_wb      (rd_wb),
    .i_imm        (imm),
    .i_br_inv     (br_inv),
    .i_rs1_data   (rs1_data),
    .i_alu_result (alu_result),
    .i_rs2_data   (rs2_data),
    .o_rf_we      (rf_we),
    .o_rf_waddr   (rf_waddr),
    .o_rf_wdata   (rf_wdata),
    .o_bus_req    (bus_req),
    .o_bus_op     (bus_op),
    .o_bus_addr   (bus_addr),
    .o_bus_wdata  (bus_wdata),
    .i_bus_done   (bus_done),
    .i_bus_rdata  (bus_rdata)
  );

  rv_decode u_decode (
    .i_insn     (insn),
    .i_pc       (pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_opcode   (opcode),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_rd_wb    (rd_wb),
    .o_imm      (imm),
    .o_alu_op   (alu_op),
    .o_op_a     (op_a),
    .o_op_b     (op_b),
    .o_br_inv   (br_inv)
  );

  rv_alu u_alu (
    .i_op     (alu_op),
    .i_a      (op_a),
    .i_b      (op_b),
    .o_result (alu_result)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .nrst     (nrst),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_we     (rf_we),
    .i_waddr  (rf_waddr),
    .i_wdata  (rf_wdata)
  );

  rv_axil_master u_axil (
    .clk       (clk),
    .nrst      (nrst),
    .i_req     (bus_req),
    .i_op      (bus_op),
    .i_addr    (bus_addr),
    .i_wdata   (bus_wdata),
    .o_done    (bus_done),
    .o_rdata   (bus_rdata),
    .o_awaddr  (o_awaddr),
    .o_awvalid (o_awvalid),
    .i_awready (i_awready),
    .o_wdata   (o_wdata),
    .o_wvalid  (o_wvalid),
    .i_wready  (i_wready),
    .i_bvalid  (i_bvalid),
    .o_bready  (o_bready),
    .o_araddr  (o_araddr),
    .o_arvalid (o_arvalid),
    .i_arready (i_arready),
    .i_rdata   (i_rdata),
    .i_rvalid  (i_rvalid),
    .o_rready  (o_rready)
  );

endmodule

// File: testbench/tb_axil_mem.sv
module tb_axil_mem (
  input  logic        clk,
  input  logic        nrst,
  input  logic [31:0] i_awaddr,
  input  logic        i_awvalid,
  output logic        o_awready,
  input  logic [31:0] i_wdata,
  input  logic        i_wvalid,
  output logic        o_wready,
  output logic        o_bvalid,
  input  logic        i_bready,
  input  logic [31:0] i_araddr,
  input  logic        i_arvalid,
  output logic        o_arready,
  output logic [31:0] o_rdata,
  output logic        o_rvalid,
  input  logic        i_rready
);

  logic [31:0] mem [256];
  integer      seed = 32'h1c5a;

  logic        ar_fire;
  logic        aw_fire;
  logic        w_fire;
  logic        r_fire;
  logic        b_fire;
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic [31:0] wr_data;
  logic        rd_busy;
  logic        aw_got;
  logic        w_got;
  int          ar_cnt;
  int          aw_cnt;
  int          w_cnt;
  int          r_cnt;
  int          b_cnt;

  // 0 to 3 cycles
  function automatic int pick_delay();
    return $unsigned($random(seed)) % 4;
  endfunction

  initial begin
    o_awready = 1'b0;
    o_wready  = 1'b0;
    o_bvalid  = 1'b0;
    o_arready = 1'b0;
    o_rvalid  = 1'b0;
    o_rdata   = '0;
  end

  // handshakes seen at the rising edge
  always @(posedge clk) begin
    ar_fire <= i_arvalid && o_arready;
    aw_fire <= i_awvalid && o_awready;
    w_fire  <= i_wvalid && o_wready;
    r_fire  <= o_rvalid && i_rready;
    b_fire  <= o_bvalid && i_bready;
    if (i_arvalid && o_arready) begin
      rd_addr <= i_araddr;
    end
    if (i_awvalid && o_awready) begin
      wr_addr <= i_awaddr;
    end
    if (i_wvalid && o_wready) begin
      wr_data <= i_wdata;
    end
  end

  always @(negedge clk) begin
    if (!nrst) begin
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      rd_busy = 1'b0;
      aw_got  = 1'b0;
      w_got   = 1'b0;
      ar_cnt  = pick_delay();
      aw_cnt  = pick_delay();
      w_cnt   = pick_delay();
      b_cnt   = pick_delay();
    end else begin
      if (ar_fire) begin
        o_arready <= 1'b0;
        rd_busy = 1'b1;
        r_cnt   = pick_delay();
      end else if (i_arvalid && !o_arready && !rd_busy) begin
        if (ar_cnt == 0) begin
          o_arready <= 1'b1;
          ar_cnt = pick_delay();
        end else begin
          ar_cnt--;
        end
      end
      if (r_fire) begin
        o_rvalid <= 1'b0;
        rd_busy = 1'b0;
      end else if (rd_busy && !o_rvalid) begin
        if (r_cnt == 0) begin
          o_rvalid <= 1'b1;
          o_rdata  <= mem[rd_addr[9:2]];
        end else begin
          r_cnt--;
        end
      end
      if (aw_fire) begin
        o_awready <= 1'b0;
        aw_got = 1'b1;
      end else if (i_awvalid && !o_awready && !aw_got) begin
        if (aw_cnt == 0) begin
          o_awready <= 1'b1;
          aw_cnt = pick_delay();
        end else begin
          aw_cnt--;
        end
      end
      if (w_fire) begin
        o_wready <= 1'b0;
        w_got = 1'b1;
      end else if (i_wvalid && !o_wready && !w_got) begin
        if (w_cnt == 0) begin
          o_wready <= 1'b1;
          w_cnt = pick_delay();
        end else begin
          w_cnt--;
        end
      end
      if (b_fire) begin
        o_bvalid <= 1'b0;
        aw_got = 1'b0;
        w_got  = 1'b0;
      end else if (aw_got && w_got && !o_bvalid) begin
        if (b_cnt == 0) begin
          mem[wr_addr[9:2]] = wr_data;
          o_bvalid <= 1'b1;
          b_cnt = pick_delay();
        end else begin
          b_cnt--;
        end
      end
    end
  end

endmodule

// File: testbench/tb_core.sv
module tb_core;

  localparam logic [31:0] POISON   = 32'h0000_023c;
  localparam int          N_STORES = 18;
  localparam int          N_READS  = 45;

  logic        clk = 1'b0;
  logic        nrst;
  logic        i_halt_req;
  logic        i_resume_req;
  logic [31:0] i_resume_pc;
  logic        o_halt;
  logic [31:0] o_awaddr;
  logic        o_awvalid;
  logic        i_awready;
  logic [31:0] o_wdata;
  logic        o_wvalid;
  logic        i_wready;
  logic        i_bvalid;
  logic        o_bready;
  logic [31:0] o_araddr;
  logic        o_arvalid;
  logic        i_arready;
  logic [31:0] i_rdata;
  logic        i_rvalid;
  logic        o_rready;

  int          cyc = 0;
  int          store_idx = 0;
  int          n_exp = 0;
  int          read_idx = 0;
  int          read_end = 0;
  int          n_read = 0;
  logic        started = 1'b0;
  logic        wr_check = 1'b0;
  logic [31:0] spin_pc = 32'h0;
  logic [31:0] read_exp;
  logic [31:0] wr_addr_q;
  logic [31:0] wr_data_q;
  logic [31:0] exp_addr [N_STORES];
  logic [31:0] exp_data [N_STORES];
  logic [31:0] exp_read [N_READS];

  always #20 clk = ~clk;

  // past the end of the list the core spins on one jump
  assign read_exp = (read_idx < read_end) ? exp_read[read_idx] : spin_pc;

  rv_core_top dut (.*);

  tb_axil_mem mem (
    .clk (clk), .nrst (nrst),
    .i_awaddr (o_awaddr), .i_awvalid (o_awvalid), .o_awready (i_awready),
    .i_wdata (o_wdata), .i_wvalid (o_wvalid), .o_wready (i_wready),
    .o_bvalid (i_bvalid), .i_bready (o_bready),
    .i_araddr (o_araddr), .i_arvalid (o_arvalid), .o_arready (i_arready),
    .o_rdata (i_rdata), .o_rvalid (i_rvalid), .i_rready (o_rready)
  );

  task automatic stop_with_failure();
    $display("TB FAILED");
    $fatal(1);
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] sw_insn(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic put(input logic [31:0] addr, input logic [31:0] insn);
    mem.mem[addr[9:2]] = insn;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr[n_exp] = addr;
    exp_data[n_exp] = data;
    n_exp++;
  endtask

  task automatic expect_read(input logic [31:0] addr);
    exp_read[n_read] = addr;
    n_read++;
  endtask

  task automatic wait_for_stores(input int n, input int limit);
    int cnt;
    cnt = 0;
    while (store_idx < n && cnt < limit) begin
      @(negedge clk);
      cnt++;
    end
    if (store_idx < n) begin
      $display("timeout: only %0d of %0d stores seen", store_idx, n);
      stop_with_failure();
    end
  endtask

  task automatic wait_for_halt(input int limit);
    int cnt;
    cnt = 0;
    while (!o_halt && cnt < limit) begin
      @(negedge clk);
      cnt++;
    end
    if (!o_halt) begin
      $display("timeout: core did not halt after the halt request");
      stop_with_failure();
    end
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (o_arvalid && i_arready && read_idx < read_end) begin
      read_idx <= read_idx + 1;
    end
    if (o_awvalid && i_awready) begin
      wr_addr_q <= o_awaddr;
    end
    if (o_wvalid && i_wready) begin
      wr_data_q <= o_wdata;
    end
    wr_check <= o_bready && i_bvalid;
    if (wr_check) begin
      store_idx <= store_idx + 1;
    end
  end

  assert property (@(posedge clk) (!started && cyc > 1) |-> o_halt)
    else begin
      $display("[ERROR] o_halt expected 1 got %h", $sampled(o_halt));
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst) !started |-> !o_arvalid && !o_awvalid)
    else begin
      $display("bus request issued before resume");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst) o_halt |-> !o_arvalid)
    else begin
      $display("read issued while halted");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst)
                   o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
    else begin
      $display("read address dropped or changed before ready");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst)
                   o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr))
    else begin
      $display("write address dropped or changed before ready");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst)
                   o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata))
    else begin
      $display("write data dropped or changed before ready");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst) o_rready |-> !o_arvalid)
    else begin
      $display("read data accepted before the read address went out");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst) o_bready |-> !o_awvalid && !o_wvalid)
    else begin
      $display("write response accepted before address and data went out");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst)
                   o_arvalid && i_arready |-> o_araddr == read_exp)
    else begin
      $display("[ERROR] o_araddr expected %h got %h", $sampled(read_exp), $sampled(o_araddr));
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst) o_awvalid |-> o_awaddr != POISON)
    else begin
      $display("store reached a skipped instruction");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst) wr_check |-> store_idx < N_STORES)
    else begin
      $display("more stores than the program contains");
      stop_with_failure();
    end
  assert property (@(posedge clk) disable iff (!nrst)
                   wr_check && store_idx < N_STORES |-> wr_addr_q == exp_addr[store_idx]
                                                        && wr_data_q == exp_data[store_idx])
    else begin
      $display("[ERROR] o_awaddr expected %h got %h, o_wdata expected %h got %h",
               exp_addr[$sampled(store_idx)], $sampled(wr_addr_q),
               exp_data[$sampled(store_idx)], $sampled(wr_data_q));
      stop_with_failure();
    end

  initial begin
    nrst         = 1'b0;
    i_halt_req   = 1'b0;
    i_resume_req = 1'b0;
    i_resume_pc  = '0;
    for (int i = 0; i < 256; i++) begin
      mem.mem[i] = (i * 32'h9e37_79b1) ^ {i[7:0], 24'h5a5a00};
    end
    // base x10, operands x1 = 5 and x2 = -3
    put(32'h00, i_type(12'h200, 0, 3'b000, 10, 7'b0010011));
    put(32'h04, i_type(12'd5, 0, 3'b000, 1, 7'b0010011));
    put(32'h08, i_type(12'hffd, 0, 3'b000, 2, 7'b0010011));
    put(32'h0c, r_type(7'h00, 2, 1, 3'b000, 3));
    put(32'h10, sw_insn(12'd0, 3, 10));
    put(32'h14, r_type(7'h20, 2, 1, 3'b000, 4));
    put(32'h18, sw_insn(12'd4, 4, 10));
    put(32'h1c, r_type(7'h00, 1, 1, 3'b001, 5));
    put(32'h20, sw_insn(12'd8, 5, 10));
    put(32'h24, r_type(7'h20, 1, 2, 3'b101, 6));
    put(32'h28, sw_insn(12'd12, 6, 10));
    put(32'h2c, r_type(7'h00, 1, 2, 3'b101, 7));
    put(32'h30, sw_insn(12'd16, 7, 10));
    put(32'h34, r_type(7'h00, 1, 2, 3'b010, 8));
    put(32'h38, sw_insn(12'd20, 8, 10));
    put(32'h3c, r_type(7'h00, 1, 2, 3'b011, 9));
    put(32'h40, sw_insn(12'd24, 9, 10));
    put(32'h44, r_type(7'h00, 2, 1, 3'b100, 11));
    put(32'h48, sw_insn(12'd28, 11, 10));
    put(32'h4c, r_type(7'h00, 2, 1, 3'b110, 12));
    put(32'h50, sw_insn(12'd32, 12, 10));
    put(32'h54, r_type(7'h00, 2, 1, 3'b111, 13));
    put(32'h58, sw_insn(12'd36, 13, 10));
    put(32'h5c, {20'h12345, 5'd14, 7'b0110111});
    put(32'h60, sw_insn(12'd40, 14, 10));
    put(32'h64, {20'h00001, 5'd15, 7'b0010111});
    put(32'h68, sw_insn(12'd44, 15, 10));
    put(32'h6c, i_type(12'd7, 1, 3'b000, 0, 7'b0010011));
    put(32'h70, sw_insn(12'd48, 0, 10));
    put(32'h74, b_type(13'd8, 1, 1, 3'b000));
    put(32'h78, sw_insn(12'd60, 1, 10));
    put(32'h7c, b_type(13'd8, 1, 1, 3'b001));
    put(32'h80, sw_insn(12'd52, 1, 10));
    put(32'h84, j_type(21'd8, 16));
    put(32'h88, sw_insn(12'd60, 1, 10));
    put(32'h8c, sw_insn(12'd56, 16, 10));
    // odd target, bit 0 must be cleared
    put(32'h90, i_type(12'h0a5, 0, 3'b000, 17, 7'b0010011));
    put(32'h94, i_type(12'd0, 17, 3'b000, 18, 7'b1100111));
    put(32'h98, sw_insn(12'd60, 1, 10));
    put(32'h9c, sw_insn(12'd60, 1, 10));
    put(32'ha0, sw_insn(12'd60, 1, 10));
    put(32'ha4, sw_insn(12'd64, 18, 10));
    put(32'ha8, i_type(12'd52, 10, 3'b010, 19, 7'b0000011));
    put(32'hac, i_type(12'd1, 19, 3'b000, 19, 7'b0010011));
    put(32'hb0, sw_insn(12'd68, 19, 10));
    put(32'hb4, j_type(21'd0, 0));
    put(32'hc0, i_type(12'h077, 0, 3'b000, 20, 7'b0010011));
    put(32'hc4, sw_insn(12'd72, 20, 10));
    put(32'hc8, j_type(21'd0, 0));

    expect_store(32'h200, 32'h0000_0002);
    expect_store(32'h204, 32'h0000_0008);
    expect_store(32'h208, 32'h0000_00a0);
    expect_store(32'h20c, 32'hffff_ffff);
    expect_store(32'h210, 32'h07ff_ffff);
    expect_store(32'h214, 32'h0000_0001);
    expect_store(32'h218, 32'h0000_0000);
    expect_store(32'h21c, 32'hffff_fff8);
    expect_store(32'h220, 32'hffff_fffd);
    expect_store(32'h224, 32'h0000_0005);
    expect_store(32'h228, 32'h1234_5000);
    expect_store(32'h22c, 32'h0000_1064);
    expect_store(32'h230, 32'h0000_0000);
    expect_store(32'h234, 32'h0000_0005);
    expect_store(32'h238, 32'h0000_0088);
    expect_store(32'h240, 32'h0000_0098);
    expect_store(32'h244, 32'h0000_0006);
    expect_store(32'h248, 32'h0000_0077);

    // read order of the first run, the load at 0xa8 reads 0x234
    for (int a = 0; a <= 32'h74; a += 4) begin
      expect_read(a);
    end
    expect_read(32'h7c);
    expect_read(32'h80);
    expect_read(32'h84);
    expect_read(32'h8c);
    expect_read(32'h90);
    expect_read(32'h94);
    expect_read(32'ha4);
    expect_read(32'ha8);
    expect_read(32'h234);
    expect_read(32'hac);
    expect_read(32'hb0);
    expect_read(32'hb4);

    repeat (8) @(negedge clk);
    nrst = 1'b1;
    repeat (5) @(negedge clk);
    started      = 1'b1;
    read_end     = n_read;
    spin_pc      = 32'hb4;
    i_resume_pc  = 32'h0;
    i_resume_req = 1'b1;
    @(negedge clk);
    i_resume_req = 1'b0;
    wait_for_stores(17, 4000);

    // core is spinning on the final jump
    repeat (20) @(negedge clk);
    i_halt_req = 1'b1;
    wait_for_halt(200);
    i_halt_req = 1'b0;
    repeat (20) @(negedge clk);

    expect_read(32'hc0);
    expect_read(32'hc4);
    expect_read(32'hc8);
    read_end     = n_read;
    spin_pc      = 32'hc8;
    i_resume_pc  = 32'hc0;
    i_resume_req = 1'b1;
    @(negedge clk);
    i_resume_req = 1'b0;
    wait_for_stores(18, 1000);
    repeat (30) @(negedge clk);

    if (store_idx == N_STORES) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("%0d stores seen, %0d expected", store_idx, N_STORES);
      stop_with_failure();
    end
  end

endmodule

// File: build.f
src/rv_core_pkg.sv
src/rv_alu.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_core_ctrl.sv
src/rv_axil_master.sv
src/rv_core_top.sv
testbench/tb_axil_mem.sv
testbench/tb_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
